// File: common/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// byte address bits actually decoded, upper address bits are ignored
`define ADDR_BITS 16

// direct-mapped, one word per line
`define CACHE_LINES 16

// main memory size in 32-bit words
`define MEM_WORDS 16384

// cycles from request accepted to ready pulse
`define MEM_LATENCY 3

`endif

// File: common/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [31:0] word_t;

    // full processor address, only the low ADDR_BITS are decoded
    typedef logic [31:0] addr_t;

    // tag sits above index and byte offset
    typedef logic [`ADDR_BITS-$clog2(`CACHE_LINES)-3:0] tag_t;
    typedef logic [$clog2(`CACHE_LINES)-1:0] index_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_compare_tag,
        ic_allocate
    } icache_state_t;

    typedef enum logic [1:0] {
        dc_idle,
        dc_compare_tag,
        dc_write_back,
        dc_allocate
    } dcache_state_t;

endpackage

// File: common/mem_pkg.sv
`include "cache_settings.svh"

package mem_pkg;

    // word address into main memory
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;

    typedef enum logic [1:0] {
        owner_none,
        owner_icache,
        owner_dcache
    } mem_owner_t;

endpackage

// File: icache/icache.sv
`timescale 1ns/10ps
`include "cache_settings.svh"

module icache (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::addr_t   cpu_addr,
    input  logic               cpu_valid,
    output cache_pkg::word_t   cpu_data,
    output logic               cpu_ready,
    output logic               mem_valid,
    output mem_pkg::mem_addr_t mem_addr,
    input  cache_pkg::word_t   mem_rdata,
    input  logic               mem_ready
);

    localparam int IDX_MSB = $clog2(`CACHE_LINES) + 1;

    cache_pkg::icache_state_t state;
    cache_pkg::icache_state_t state_next;

    logic [`CACHE_LINES-1:0] line_valid;
    cache_pkg::tag_t         tag_mem [`CACHE_LINES];
    cache_pkg::word_t        data_mem [`CACHE_LINES];

    cache_pkg::index_t index;
    cache_pkg::tag_t   tag;
    logic              hit;

    assign index = cpu_addr[IDX_MSB:2];
    assign tag   = cpu_addr[`ADDR_BITS-1:IDX_MSB+1];
    assign hit   = line_valid[index] && (tag_mem[index] == tag);

    // word of the requested line, qualified by cpu_ready
    assign cpu_data = data_mem[index];

    // refill fetches the requested word itself
    assign mem_addr = cpu_addr[`ADDR_BITS-1:2];

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= cache_pkg::ic_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        cpu_ready  = 1'b0;
        mem_valid  = 1'b0;
        case (state)
            cache_pkg::ic_idle:
            begin
                if (cpu_valid)
                    state_next = cache_pkg::ic_compare_tag;
            end
            cache_pkg::ic_compare_tag:
            begin
                if (hit)
                begin
                    cpu_ready  = 1'b1;
                    state_next = cache_pkg::ic_idle;
                end
                else
                begin
                    state_next = cache_pkg::ic_allocate;
                end
            end
            cache_pkg::ic_allocate:
            begin
                // held until the arbiter passes the memory ready back
                mem_valid = 1'b1;
                if (mem_ready)
                    state_next = cache_pkg::ic_compare_tag;
            end
            default:
            begin
                state_next = cache_pkg::ic_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            line_valid <= '0;
        else if (state == cache_pkg::ic_allocate && mem_ready)
            line_valid[index] <= 1'b1;
    end

    // line fill
    always_ff @(posedge clk)
    begin
        if (state == cache_pkg::ic_allocate && mem_ready)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= mem_rdata;
        end
    end

endmodule

// File: dcache/dcache.sv
`timescale 1ns/10ps
`include "cache_settings.svh"

module dcache (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::addr_t   cpu_addr,
    input  cache_pkg::word_t   cpu_wdata,
    input  logic               cpu_we,
    input  logic               cpu_valid,
    output cache_pkg::word_t   cpu_rdata,
    output logic               cpu_ready,
    output logic               mem_valid,
    output logic               mem_we,
    output mem_pkg::mem_addr_t mem_addr,
    output cache_pkg::word_t   mem_wdata,
    input  cache_pkg::word_t   mem_rdata,
    input  logic               mem_ready
);

    localparam int IDX_MSB = $clog2(`CACHE_LINES) + 1;

    cache_pkg::dcache_state_t state;
    cache_pkg::dcache_state_t state_next;

    logic [`CACHE_LINES-1:0] line_valid;
    logic [`CACHE_LINES-1:0] line_dirty;
    cache_pkg::tag_t         tag_mem [`CACHE_LINES];
    cache_pkg::word_t        data_mem [`CACHE_LINES];

    cache_pkg::index_t index;
    cache_pkg::tag_t   tag;
    logic              hit;
    logic              victim_dirty;
    logic              write_hit;
    logic              fill_done;

    assign index = cpu_addr[IDX_MSB:2];
    assign tag   = cpu_addr[`ADDR_BITS-1:IDX_MSB+1];
    assign hit   = line_valid[index] && (tag_mem[index] == tag);

    // a valid dirty line under another tag has to go back first
    assign victim_dirty = line_valid[index] && line_dirty[index];

    assign write_hit = (state == cache_pkg::dc_compare_tag) && hit && cpu_we;
    assign fill_done = (state == cache_pkg::dc_allocate) && mem_ready;

    assign cpu_rdata = data_mem[index];

    // only sampled by memory during write-back
    assign mem_wdata = data_mem[index];

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= cache_pkg::dc_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        cpu_ready  = 1'b0;
        mem_valid  = 1'b0;
        mem_we     = 1'b0;
        mem_addr   = cpu_addr[`ADDR_BITS-1:2];
        case (state)
            cache_pkg::dc_idle:
            begin
                if (cpu_valid)
                    state_next = cache_pkg::dc_compare_tag;
            end
            cache_pkg::dc_compare_tag:
            begin
                if (hit)
                begin
                    cpu_ready  = 1'b1;
                    state_next = cache_pkg::dc_idle;
                end
                else if (victim_dirty)
                begin
                    state_next = cache_pkg::dc_write_back;
                end
                else
                begin
                    state_next = cache_pkg::dc_allocate;
                end
            end
            cache_pkg::dc_write_back:
            begin
                // old line goes back to its own address
                mem_valid = 1'b1;
                mem_we    = 1'b1;
                mem_addr  = {tag_mem[index], index};
                if (mem_ready)
                    state_next = cache_pkg::dc_allocate;
            end
            cache_pkg::dc_allocate:
            begin
                mem_valid = 1'b1;
                if (mem_ready)
                    state_next = cache_pkg::dc_compare_tag;
            end
            default:
            begin
                state_next = cache_pkg::dc_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_valid <= '0;
            line_dirty <= '0;
        end
        else if (write_hit)
        begin
            line_dirty[index] <= 1'b1;
        end
        else if (state == cache_pkg::dc_write_back && mem_ready)
        begin
            line_dirty[index] <= 1'b0;
        end
        else if (fill_done)
        begin
            line_valid[index] <= 1'b1;
            line_dirty[index] <= 1'b0;
        end
    end

    // write miss lands here too, on the compare_tag hit after the fill
    always_ff @(posedge clk)
    begin
        if (write_hit)
        begin
            data_mem[index] <= cpu_wdata;
        end
        else if (fill_done)
        begin
            data_mem[index] <= mem_rdata;
            tag_mem[index]  <= tag;
        end
    end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_valid,
    input  mem_pkg::mem_addr_t i_addr,
    output cache_pkg::word_t   i_rdata,
    output logic               i_ready,
    input  logic               d_valid,
    input  logic               d_we,
    input  mem_pkg::mem_addr_t d_addr,
    input  cache_pkg::word_t   d_wdata,
    output cache_pkg::word_t   d_rdata,
    output logic               d_ready,
    output logic               req,
    output logic               we,
    output mem_pkg::mem_addr_t addr,
    output cache_pkg::word_t   wdata,
    input  cache_pkg::word_t   rdata,
    input  logic               ready
);

    mem_pkg::mem_owner_t owner;
    mem_pkg::mem_owner_t grant;
    logic                last_dcache;

    // held owner wins, otherwise pick combinationally so no cycle is lost
    always_comb
    begin
        if (owner != mem_pkg::owner_none)
            grant = owner;
        else if (i_valid && d_valid)
            grant = last_dcache ? mem_pkg::owner_icache : mem_pkg::owner_dcache;
        else if (i_valid)
            grant = mem_pkg::owner_icache;
        else if (d_valid)
            grant = mem_pkg::owner_dcache;
        else
            grant = mem_pkg::owner_none;
    end

    always_comb
    begin
        req  = 1'b0;
        we   = 1'b0;
        addr = i_addr;
        case (grant)
            mem_pkg::owner_icache:
            begin
                req  = i_valid;
                addr = i_addr;
            end
            mem_pkg::owner_dcache:
            begin
                req  = d_valid;
                we   = d_we;
                addr = d_addr;
            end
            default:
            begin
                req = 1'b0;
            end
        endcase
    end

    // icache never writes
    assign wdata = d_wdata;

    assign i_rdata = rdata;
    assign d_rdata = rdata;
    assign i_ready = ready && (owner == mem_pkg::owner_icache);
    assign d_ready = ready && (owner == mem_pkg::owner_dcache);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            owner       <= mem_pkg::owner_none;
            last_dcache <= 1'b0;
        end
        else if (ready)
        begin
            owner       <= mem_pkg::owner_none;
            last_dcache <= (owner == mem_pkg::owner_dcache);
        end
        else if (owner == mem_pkg::owner_none && grant != mem_pkg::owner_none)
        begin
            owner <= grant;
        end
    end

endmodule

// File: design/main_memory.sv
`timescale 1ns/10ps
`include "cache_settings.svh"

module main_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  logic               we,
    input  mem_pkg::mem_addr_t addr,
    input  cache_pkg::word_t   wdata,
    output cache_pkg::word_t   rdata,
    output logic               ready
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    cache_pkg::word_t mem_array [`MEM_WORDS];

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic             access;

    initial
    begin
        for (int i = 0; i < `MEM_WORDS; i++)
            mem_array[i] = '0;
    end

    // last counted cycle, ready rises at the next edge
    assign access = busy && (cnt == CNT_W'(1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy  <= 1'b0;
            cnt   <= '0;
            ready <= 1'b0;
        end
        else
        begin
            ready <= access;
            // no accept while ready is high, gives the idle cycle
            if (!busy && !ready && req)
            begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`MEM_LATENCY - 1);
            end
            else if (busy)
            begin
                cnt <= cnt - CNT_W'(1);
                if (access)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            if (we)
                mem_array[addr] <= wdata;
            rdata <= mem_array[addr];
        end
    end

endmodule

// File: design/cache_top.sv
`timescale 1ns/10ps

module cache_top (
    input  logic             clk,
    input  logic             rst,
    input  cache_pkg::addr_t if_addr,
    input  logic             if_valid,
    output cache_pkg::word_t if_data,
    output logic             if_ready,
    input  cache_pkg::addr_t d_addr,
    input  cache_pkg::word_t d_wdata,
    input  logic             d_we,
    input  logic             d_valid,
    output cache_pkg::word_t d_rdata,
    output logic             d_ready
);

    // icache to arbiter
    logic               ic_mem_valid;
    mem_pkg::mem_addr_t ic_mem_addr;
    cache_pkg::word_t   ic_mem_rdata;
    logic               ic_mem_ready;

    // dcache to arbiter
    logic               dc_mem_valid;
    logic               dc_mem_we;
    mem_pkg::mem_addr_t dc_mem_addr;
    cache_pkg::word_t   dc_mem_wdata;
    cache_pkg::word_t   dc_mem_rdata;
    logic               dc_mem_ready;

    // arbiter to memory
    logic               mem_req;
    logic               mem_we;
    mem_pkg::mem_addr_t mem_addr;
    cache_pkg::word_t   mem_wdata;
    cache_pkg::word_t   mem_rdata;
    logic               mem_ready;

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (if_addr),
        .cpu_valid (if_valid),
        .cpu_data  (if_data),
        .cpu_ready (if_ready),
        .mem_valid (ic_mem_valid),
        .mem_addr  (ic_mem_addr),
        .mem_rdata (ic_mem_rdata),
        .mem_ready (ic_mem_ready)
    );

    dcache u_dcache (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (d_addr),
        .cpu_wdata (d_wdata),
        .cpu_we    (d_we),
        .cpu_valid (d_valid),
        .cpu_rdata (d_rdata),
        .cpu_ready (d_ready),
        .mem_valid (dc_mem_valid),
        .mem_we    (dc_mem_we),
        .mem_addr  (dc_mem_addr),
        .mem_wdata (dc_mem_wdata),
        .mem_rdata (dc_mem_rdata),
        .mem_ready (dc_mem_ready)
    );

    mem_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .i_valid (ic_mem_valid),
        .i_addr  (ic_mem_addr),
        .i_rdata (ic_mem_rdata),
        .i_ready (ic_mem_ready),
        .d_valid (dc_mem_valid),
        .d_we    (dc_mem_we),
        .d_addr  (dc_mem_addr),
        .d_wdata (dc_mem_wdata),
        .d_rdata (dc_mem_rdata),
        .d_ready (dc_mem_ready),
        .req     (mem_req),
        .we      (mem_we),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata),
        .ready   (mem_ready)
    );

    main_memory u_memory (
        .clk   (clk),
        .rst   (rst),
        .req   (mem_req),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata),
        .ready (mem_ready)
    );

endmodule

// File: sim/cache_assert.sv
`timescale 1ns/10ps

module cache_assert (
    input logic clk,
    input logic rst,
    input logic i_ready,
    input logic d_ready,
    input logic req,
    input logic ready
);

    int violations = 0;

    // memory answers one cache at a time
    one_ready: assert property (@(posedge clk) disable iff (rst) !(i_ready && d_ready))
    else
    begin
        violations++;
        $error("ready returned to both caches in one cycle");
    end

    req_held: assert property (@(posedge clk) disable iff (rst) req && !ready |=> req)
    else
    begin
        violations++;
        $error("memory request dropped before ready");
    end

    ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
    else
    begin
        violations++;
        $error("memory ready high for two cycles");
    end

endmodule

bind mem_arbiter cache_assert arb_checks (
    .clk     (clk),
    .rst     (rst),
    .i_ready (i_ready),
    .d_ready (d_ready),
    .req     (req),
    .ready   (ready)
);

// memory side has a single ready, the cache pair rule is tied off
bind main_memory cache_assert mem_checks (
    .clk     (clk),
    .rst     (rst),
    .i_ready (1'b0),
    .d_ready (1'b0),
    .req     (req),
    .ready   (ready)
);

// File: sim/cache_tb.sv
`timescale 1ns/10ps
`include "cache_settings.svh"

module cache_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RANDOM_OPS = 100;
    // one word for each fetch address the random traffic can reach
    localparam int FETCH_WORDS = 64;
    // 9 directed requests plus the preload and its evicting reads
    localparam int NUM_REQUESTS = 9 + FETCH_WORDS + `CACHE_LINES + 2 * RANDOM_OPS;
    localparam int TIMEOUT_NS = (NUM_REQUESTS * 20 + 10) * CLK_PERIOD;

    logic             clk;
    logic             rst;
    cache_pkg::addr_t if_addr;
    logic             if_valid;
    cache_pkg::word_t if_data;
    logic             if_ready;
    cache_pkg::addr_t d_addr;
    cache_pkg::word_t d_wdata;
    logic             d_we;
    logic             d_valid;
    cache_pkg::word_t d_rdata;
    logic             d_ready;

    // main memory as seen after write-backs
    cache_pkg::word_t model_mem [mem_pkg::mem_addr_t];

    logic [`CACHE_LINES-1:0] ic_valid;
    cache_pkg::tag_t         ic_tag [`CACHE_LINES];
    cache_pkg::word_t        ic_data [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] dc_valid;
    logic [`CACHE_LINES-1:0] dc_dirty;
    cache_pkg::tag_t         dc_tag [`CACHE_LINES];
    cache_pkg::word_t        dc_data [`CACHE_LINES];

    // pending responses in issue order per port
    cache_pkg::word_t if_exp_q [$];
    int               if_lat_q [$];
    cache_pkg::word_t d_exp_q [$];
    int               d_lat_q [$];
    bit               d_chk_q [$];
    int               if_cycles;
    int               d_cycles;

    int               seed;
    logic [31:0]      rnd;
    cache_pkg::addr_t rnd_fetch_addr [RANDOM_OPS];
    cache_pkg::addr_t rnd_data_addr [RANDOM_OPS];
    logic             rnd_data_we [RANDOM_OPS];
    cache_pkg::word_t rnd_data_wdata [RANDOM_OPS];

    cache_top UUT (
        .clk      (clk),
        .rst      (rst),
        .if_addr  (if_addr),
        .if_valid (if_valid),
        .if_data  (if_data),
        .if_ready (if_ready),
        .d_addr   (d_addr),
        .d_wdata  (d_wdata),
        .d_we     (d_we),
        .d_valid  (d_valid),
        .d_rdata  (d_rdata),
        .d_ready  (d_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopped at first failing check");
    endtask

    // unwritten words read as zero
    function automatic cache_pkg::word_t mem_read(input mem_pkg::mem_addr_t w);
        if (model_mem.exists(w))
            return model_mem[w];
        return '0;
    endfunction

    function automatic int assert_violations();
        return UUT.u_arbiter.arb_checks.violations + UUT.u_memory.mem_checks.violations;
    endfunction

    // address tag is 15:6 and index 5:2
    // updates the modeled lines and returns the word the port delivers
    function automatic cache_pkg::word_t expected_word(input bit fetch_side,
                                                       input cache_pkg::addr_t a,
                                                       input logic we,
                                                       input cache_pkg::word_t wdata);
        cache_pkg::index_t idx;
        cache_pkg::tag_t   tg;
        idx = a[5:2];
        tg  = a[15:6];
        if (fetch_side)
        begin
            // icache keeps whatever memory held when the line was filled
            if (!(ic_valid[idx] && ic_tag[idx] == tg))
            begin
                ic_valid[idx] = 1'b1;
                ic_tag[idx]   = tg;
                ic_data[idx]  = mem_read(a[15:2]);
            end
            return ic_data[idx];
        end
        if (!(dc_valid[idx] && dc_tag[idx] == tg))
        begin
            if (dc_valid[idx] && dc_dirty[idx])
                model_mem[{dc_tag[idx], idx}] = dc_data[idx];
            dc_valid[idx] = 1'b1;
            dc_dirty[idx] = 1'b0;
            dc_tag[idx]   = tg;
            dc_data[idx]  = mem_read(a[15:2]);
        end
        if (we)
        begin
            dc_data[idx]  = wdata;
            dc_dirty[idx] = 1'b1;
        end
        return dc_data[idx];
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic fetch(input cache_pkg::addr_t a, input int exp_cycles);
        if_exp_q.push_back(expected_word(1'b1, a, 1'b0, '0));
        if_lat_q.push_back(exp_cycles);
        if_addr  = a;
        if_valid = 1'b1;
        @(negedge clk);
        while (!if_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        if_valid = 1'b0;
    endtask

    task automatic data_access(input cache_pkg::addr_t a, input logic we,
                               input cache_pkg::word_t wdata, input int exp_cycles);
        d_exp_q.push_back(expected_word(1'b0, a, we, wdata));
        d_chk_q.push_back(!we);
        d_lat_q.push_back(exp_cycles);
        d_addr  = a;
        d_we    = we;
        d_wdata = wdata;
        d_valid = 1'b1;
        @(negedge clk);
        while (!d_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        d_valid = 1'b0;
    endtask

    // ready is combinational so compare in the middle of the cycle
    always @(negedge clk)
    begin
        cache_pkg::word_t exp_data;
        int               exp_lat;
        bit               exp_chk;
        assert (assert_violations() == 0)
        else fail_now("a handshake assertion on the memory side fired");
        if (!rst && if_valid)
        begin
            if_cycles = if_cycles + 1;
            if (if_ready)
            begin
                exp_data = if_exp_q.pop_front();
                exp_lat  = if_lat_q.pop_front();
                assert (if_data == exp_data)
                else fail_now($sformatf("CHECK FAILED at %0t: fetch %h gave %h, expected %h",
                                        $time, if_addr, if_data, exp_data));
                assert (exp_lat == 0 || if_cycles == exp_lat)
                else fail_now($sformatf("CHECK FAILED at %0t: fetch %h took %0d cycles, not %0d",
                                        $time, if_addr, if_cycles, exp_lat));
                if_cycles = 0;
            end
        end
        if (!rst && d_valid)
        begin
            d_cycles = d_cycles + 1;
            if (d_ready)
            begin
                exp_data = d_exp_q.pop_front();
                exp_chk  = d_chk_q.pop_front();
                exp_lat  = d_lat_q.pop_front();
                assert (!exp_chk || d_rdata == exp_data)
                else fail_now($sformatf("CHECK FAILED at %0t: load %h gave %h, expected %h",
                                        $time, d_addr, d_rdata, exp_data));
                assert (exp_lat == 0 || d_cycles == exp_lat)
                else fail_now($sformatf("CHECK FAILED at %0t: load %h took %0d cycles, not %0d",
                                        $time, d_addr, d_cycles, exp_lat));
                d_cycles = 0;
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: requests still pending after %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        seed      = 32'he791;
        rst       = 1'b1;
        if_addr   = '0;
        if_valid  = 1'b0;
        d_addr    = '0;
        d_wdata   = '0;
        d_we      = 1'b0;
        d_valid   = 1'b0;
        ic_valid  = '0;
        dc_valid  = '0;
        dc_dirty  = '0;
        if_cycles = 0;
        d_cycles  = 0;
        // random fetches read the preloaded words while random data stays below 0x100
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            rnd = $random(seed);
            rnd_fetch_addr[i] = 32'h0000_8000 | (rnd & 32'h0000_00fc);
            rnd = $random(seed);
            rnd_data_addr[i] = rnd & 32'h0000_00fc;
            rnd_data_we[i]   = rnd[16];
            rnd_data_wdata[i] = $random(seed);
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        fetch(32'h0000_8040, 0);
        fetch(32'h0000_8040, 2);
        data_access(32'h0000_0104, 1'b1, 32'h1234_5678, 0);
        data_access(32'h0000_0104, 1'b0, '0, 2);
        // two tags on index 2
        data_access(32'h0000_0208, 1'b1, 32'ha5a5_0001, 0);
        data_access(32'h0000_0608, 1'b1, 32'h5a5a_0002, 0);
        data_access(32'h0000_0208, 1'b0, '0, 0);
        fetch(32'h0000_0208, 0);
        fetch(32'h0000_0608, 0);

        // fetch words get their contents through dcache write-backs
        for (int i = 0; i < FETCH_WORDS; i++)
        begin
            rnd = $random(seed);
            data_access(32'h0000_8000 + 4 * i, 1'b1, rnd, 0);
        end
        // low reads evict the last dirty fetch lines
        for (int i = 0; i < `CACHE_LINES; i++)
            data_access(4 * i, 1'b0, '0, 0);

        fork
            begin
                for (int i = 0; i < RANDOM_OPS; i++)
                    fetch(rnd_fetch_addr[i], 0);
            end
            begin
                for (int j = 0; j < RANDOM_OPS; j++)
                    data_access(rnd_data_addr[j], rnd_data_we[j], rnd_data_wdata[j], 0);
            end
        join

        repeat (2) @(posedge clk);
        if (if_exp_q.size() == 0 && d_exp_q.size() == 0 && assert_violations() == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("Responses missing or handshake assertions fired at the end of the run");
            $display("Checks failed");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

// File: list.f
+incdir+common
common/cache_pkg.sv
common/mem_pkg.sv
icache/icache.sv
dcache/dcache.sv
design/mem_arbiter.sv
design/main_memory.sv
design/cache_top.sv
sim/cache_assert.sv
sim/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let assertion errors reach the testbench instead of stopping at the first one
out=$(./obj_dir/Vcache_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
echo "pass message not found"
exit 1
